// ==== Makefile ====
# Verilator build and run of the arbiter testbench
TOP = tb_tmr_rr_arb

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== arb_pkg.sv ====
// vector types shared by the arbiter RTL and its testbench
// index, request vector, payload word and node select vector
`include "arb_settings.svh"

package arb_pkg;

  // an input index or the round-robin priority pointer
  typedef logic [`ARB_IDX_W-1:0] idx_t;

  // one bit per input, used for requests and for grants
  typedef logic [`ARB_NUM_IN-1:0] req_vec_t;

  // one payload word
  typedef logic [`ARB_DATA_W-1:0] data_t;

  // one select bit per internal tree node
  // node 0 is the root, node n has children 2n+1 (lower) and 2n+2 (upper)
  // a set bit means the node passes on its upper child
  typedef logic [`ARB_NODES-1:0] node_sel_t;

endpackage

// ==== arb_settings.svh ====
// size macros for the triple-redundant round-robin arbiter
// input count, payload width, index width and tree node count
`ifndef ARB_SETTINGS_SVH
`define ARB_SETTINGS_SVH

// number of arbitrated inputs
// the tree is built without partial leaves, so this has to be a power of two
`define ARB_NUM_IN 8

// payload width of every input in bits
`define ARB_DATA_W 32

// bits needed for an input index and for the priority pointer
`define ARB_IDX_W 3

// internal nodes of the binary tree, one fewer than the inputs
`define ARB_NODES 7

`endif

// ==== arb_tree.sv ====
// combinational round-robin tree of one replica
// requests and index go up, the grant comes down the chosen path
`timescale 1ns/1ps
`include "arb_settings.svh"

module arb_tree import arb_pkg::*; (
  input  req_vec_t  req_eff_i,
  input  idx_t      rr_i,
  input  logic      gnt_i,
  output logic      req_o,
  output idx_t      idx_o,
  output req_vec_t  gnt_o,
  output node_sel_t node_sel_o
);

  // per-node request, grant and partial index
  logic req_nodes [`ARB_NODES];
  logic gnt_nodes [`ARB_NODES];
  idx_t idx_nodes [`ARB_NODES];

  // the root faces the downstream side
  assign req_o        = req_nodes[0];
  assign idx_o        = idx_nodes[0];
  assign gnt_nodes[0] = gnt_i;

  // level 0 is the root and takes the pointer MSB
  // the leaf level sits right above the inputs and takes pointer bit 0
  for (genvar lv = 0; lv < `ARB_IDX_W; lv++) begin : gen_levels
    for (genvar l = 0; l < 2 ** lv; l++) begin : gen_nodes
      localparam int unsigned node  = 2 ** lv - 1 + l;
      localparam int unsigned c_lo  = 2 * node + 1;
      localparam int unsigned c_hi  = 2 * node + 2;
      localparam int unsigned rr_bit = `ARB_IDX_W - 1 - lv;

      ////////////////////////////////////////
      // leaf nodes fed by the inputs
      ////////////////////////////////////////
      if (lv == `ARB_IDX_W - 1) begin : gen_leaf
        assign req_nodes[node] = req_eff_i[2*l] | req_eff_i[2*l+1];

        // upper input when the lower is idle, or both request and the pointer says so
        assign node_sel_o[node] = ~req_eff_i[2*l] | (req_eff_i[2*l+1] & rr_i[rr_bit]);

        // the leaf only decides the index LSB
        assign idx_nodes[node] = idx_t'(node_sel_o[node]);

        // a grant reaches an input only if it is requesting and chosen
        assign gnt_o[2*l]   = gnt_nodes[node] & req_eff_i[2*l]   & ~node_sel_o[node];
        assign gnt_o[2*l+1] = gnt_nodes[node] & req_eff_i[2*l+1] &  node_sel_o[node];

      ////////////////////////////////////////
      // inner nodes fed by two child nodes
      ////////////////////////////////////////
      end else begin : gen_inner
        assign req_nodes[node] = req_nodes[c_lo] | req_nodes[c_hi];

        // same rule as the leaves, with the pointer bit of this level
        assign node_sel_o[node] = ~req_nodes[c_lo] | (req_nodes[c_hi] & rr_i[rr_bit]);

        // take the chosen child's lower bits and add this level's bit on top
        // the child index is zero above its own level, so an OR is enough
        assign idx_nodes[node] =
          (node_sel_o[node] ? idx_nodes[c_hi] : idx_nodes[c_lo]) |
          (idx_t'(node_sel_o[node]) << rr_bit);

        // pass the grant to the chosen child only
        assign gnt_nodes[c_lo] = gnt_nodes[node] & ~node_sel_o[node];
        assign gnt_nodes[c_hi] = gnt_nodes[node] &  node_sel_o[node];
      end
    end
  end

endmodule

// ==== data_mux_tree.sv ====
// payload multiplexer tree steered by the voted node selects
// one vote over the three replicas' select vectors
`timescale 1ns/1ps
`include "arb_settings.svh"

module data_mux_tree import arb_pkg::*; (
  input  node_sel_t [2:0]              node_sel_i,
  input  data_t     [`ARB_NUM_IN-1:0]  data_i,
  output data_t                        data_o,
  output logic                         fault_o
);

  node_sel_t sel_voted;
  data_t     data_nodes [`ARB_NODES];

  // the payload path follows the majority decision of the three trees
  tmr_voter #(.WIDTH(`ARB_NODES)) i_sel_vote (
    .a_i        (node_sel_i[0]),
    .b_i        (node_sel_i[1]),
    .c_i        (node_sel_i[2]),
    .majority_o (sel_voted),
    .fault_o    (fault_o)
  );

  // same node numbering as the arbitration tree
  for (genvar lv = 0; lv < `ARB_IDX_W; lv++) begin : gen_levels
    for (genvar l = 0; l < 2 ** lv; l++) begin : gen_nodes
      localparam int unsigned node = 2 ** lv - 1 + l;
      localparam int unsigned c_lo = 2 * node + 1;
      localparam int unsigned c_hi = 2 * node + 2;

      if (lv == `ARB_IDX_W - 1) begin : gen_leaf
        // leaves pick between two neighbouring inputs
        assign data_nodes[node] = sel_voted[node] ? data_i[2*l+1] : data_i[2*l];
      end else begin : gen_inner
        assign data_nodes[node] = sel_voted[node] ? data_nodes[c_hi] : data_nodes[c_lo];
      end
    end
  end

  // the root holds the winning payload
  assign data_o = data_nodes[0];

endmodule

// ==== flist.f ====
+incdir+.
arb_pkg.sv
tmr_voter.sv
rr_state.sv
arb_tree.sv
data_mux_tree.sv
tmr_rr_arb.sv
tb_tmr_rr_arb.sv

// ==== rr_state.sv ====
// state of one arbiter replica with the fair next-pointer search
// pointer, lock flag and held requests, each voted with the peer replicas
`timescale 1ns/1ps
`include "arb_settings.svh"

module rr_state import arb_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           flush_i,
  input  req_vec_t       req_i,
  input  logic           req_out_i,
  input  logic           gnt_i,
  input  idx_t     [1:0] peer_rr_i,
  input  logic     [1:0] peer_lock_i,
  input  req_vec_t [1:0] peer_req_i,
  output idx_t           rr_next_o,
  output logic           lock_next_o,
  output req_vec_t       req_next_o,
  output idx_t           rr_o,
  output req_vec_t       req_eff_o,
  output logic           fault_o
);

  idx_t     rr_q, rr_d, rr_voted;
  logic     lock_q, lock_d, lock_voted;
  req_vec_t req_q, req_eff, req_voted;
  idx_t     served_idx, served_dist;
  idx_t     upper_idx, lower_idx;
  logic     upper_any;
  logic     rr_fault, lock_fault, req_fault;

  ////////////////////////////////////////
  // lock-in
  ////////////////////////////////////////

  // while locked the tree sees the vector held at the stalled edge
  // so the arbitration decision cannot move until it is served
  assign req_eff = lock_q ? req_q : req_i;

  // a request that goes out without a grant locks the decision
  assign lock_d = req_out_i & ~gnt_i;

  ////////////////////////////////////////
  // fair next-pointer search
  ////////////////////////////////////////

  always_comb begin : p_next_idx
    served_idx  = rr_q;
    served_dist = '1;
    upper_idx   = '0;
    lower_idx   = '0;
    upper_any   = 1'b0;
    // the tree descends towards the pointer wherever that half requests
    // so it serves the requester with the smallest XOR distance to the pointer
    for (int i = 0; i < `ARB_NUM_IN; i++) begin
      if (req_eff[i] && ((idx_t'(i) ^ rr_q) <= served_dist)) begin
        served_idx  = idx_t'(i);
        served_dist = idx_t'(i) ^ rr_q;
      end
    end
    // scan from the top so that the lowest set bit in each half wins
    // the upper half holds requests above the served input, the lower half the rest
    for (int i = `ARB_NUM_IN - 1; i >= 0; i--) begin
      if (req_eff[i]) begin
        if (idx_t'(i) > served_idx) begin
          upper_idx = idx_t'(i);
          upper_any = 1'b1;
        end else begin
          lower_idx = idx_t'(i);
        end
      end
    end
  end

  // the pointer only moves on a transfer, and wraps when nothing is above it
  assign rr_d = (req_out_i && gnt_i) ? (upper_any ? upper_idx : lower_idx) : rr_q;

  // unvoted next values go out to the two peer replicas
  assign rr_next_o   = rr_d;
  assign lock_next_o = lock_d;
  assign req_next_o  = req_eff;

  ////////////////////////////////////////
  // peer vote and registers
  ////////////////////////////////////////

  tmr_voter #(.WIDTH(`ARB_IDX_W)) i_rr_vote (
    .a_i        (rr_d),
    .b_i        (peer_rr_i[0]),
    .c_i        (peer_rr_i[1]),
    .majority_o (rr_voted),
    .fault_o    (rr_fault)
  );

  tmr_voter #(.WIDTH(1)) i_lock_vote (
    .a_i        (lock_d),
    .b_i        (peer_lock_i[0]),
    .c_i        (peer_lock_i[1]),
    .majority_o (lock_voted),
    .fault_o    (lock_fault)
  );

  tmr_voter #(.WIDTH(`ARB_NUM_IN)) i_req_vote (
    .a_i        (req_eff),
    .b_i        (peer_req_i[0]),
    .c_i        (peer_req_i[1]),
    .majority_o (req_voted),
    .fault_o    (req_fault)
  );

  // each register takes the majority, so one upset replica is corrected
  // at the next edge
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state_regs
    if (!rst_ni) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      req_q  <= '0;
    end else if (flush_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      req_q  <= '0;
    end else begin
      rr_q   <= rr_voted;
      lock_q <= lock_voted;
      req_q  <= req_voted;
    end
  end

  assign rr_o      = rr_q;
  assign req_eff_o = req_eff;
  assign fault_o   = rr_fault | lock_fault | req_fault;

endmodule

// ==== tb_tmr_rr_arb.sv ====
// testbench for the triple-redundant round-robin arbiter
// clock, reset, stimulus tasks, reference winner function, checker and watchdog
`timescale 1ns/1ps
`include "arb_settings.svh"

module tb_tmr_rr_arb import arb_pkg::*; ();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;
  localparam int ROT_XFERS    = 12;
  localparam int RAND_CYCLES  = 300;
  localparam int LOCK_HOLD    = 3;
  localparam int FLUSH_XFERS  = 6;
  localparam int DRAIN_CYCLES = 3;
  localparam int XFER_LIMIT   = 20;
  // every test length plus the drains and some slack
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + ROT_XFERS + RAND_CYCLES + LOCK_HOLD +
                                   FLUSH_XFERS + 4 * DRAIN_CYCLES + 100;

  localparam req_vec_t ROT_REQ   = 8'b1011_0110;
  localparam req_vec_t LOCK_REQ  = 8'b0100_1000;
  localparam req_vec_t FLUSH_REQ = 8'b0101_1010;

  logic                       clk_i, rst_ni, flush_i, gnt_i;
  req_vec_t                   req_i;
  data_t    [`ARB_NUM_IN-1:0] data_i;
  logic                       req_o, fault_o;
  req_vec_t                   gnt_o;
  idx_t                       idx_o;
  data_t                      data_o;

  logic        check_en, ref_en;
  int          errors, check_count, fault_cycles, last_served;
  logic [31:0] seed;

  tmr_rr_arb dut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .req_i   (req_i),
    .data_i  (data_i),
    .gnt_i   (gnt_i),
    .req_o   (req_o),
    .gnt_o   (gnt_o),
    .idx_o   (idx_o),
    .data_o  (data_o),
    .fault_o (fault_o)
  );

  initial begin : p_clock
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // linear congruential generator, one step per call
  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // expected winner: lowest requester above the last served input, wrapping
  // a last index of -1 means nothing was served yet, so the lowest one wins
  function automatic int ref_next_grant(input req_vec_t req, input int last);
    int pick;
    pick = -1;
    for (int i = `ARB_NUM_IN - 1; i > last; i--) begin
      if (req[i]) begin
        pick = i;
      end
    end
    if (pick < 0) begin
      for (int i = `ARB_NUM_IN - 1; i >= 0; i--) begin
        if (req[i]) begin
          pick = i;
        end
      end
    end
    return pick;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      errors++;
      $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
    end
  endtask

  task automatic fill_random_data();
    for (int i = 0; i < `ARB_NUM_IN; i++) begin
      data_i[i] = next_random();
    end
  endtask

  // waits for a cycle with req_o and gnt_i both high and returns the served index
  task automatic wait_transfer(output int idx);
    int waited;
    waited = 0;
    idx = -1;
    @(negedge clk_i);
    while (!(req_o && gnt_i) && waited < XFER_LIMIT) begin
      waited++;
      @(negedge clk_i);
    end
    if (req_o && gnt_i) begin
      idx = int'(idx_o);
    end else begin
      errors++;
      $display("no transfer within %0d cycles at %0d ns", XFER_LIMIT, $time);
    end
  endtask

  // serve whatever is locked, then drop all requests and flush to a clean state
  task automatic drain();
    gnt_i = 1'b1;
    @(posedge clk_i);
    #1;
    req_i   = '0;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    @(posedge clk_i);
    #1;
  endtask

  task automatic report_test(input int num, input string name, input int err_start);
    $display("test %0d %s: %0d errors", num, name, errors - err_start);
  endtask

  ////////////////////////////////////////
  // per-cycle checker
  ////////////////////////////////////////

  // outputs are combinational, so the falling edge sees them settled
  always @(negedge clk_i) begin : p_checker
    int exp_idx;
    if (!rst_ni) begin
      last_served = -1;
    end else if (check_en) begin
      if (fault_o !== 1'b0) begin
        fault_cycles++;
      end
      check_value("fault_o", 32'(fault_o), 32'd0);
      check_value("req_o", 32'(req_o), 32'(|req_i));
      check_value("data_o", data_o, data_i[idx_o]);
      if (req_o && gnt_i) begin
        // one-hot grant back to a requesting input
        check_value("gnt_o", 32'(gnt_o), 32'(req_vec_t'(1) << idx_o));
        check_value("req_i at idx_o", 32'(req_i[idx_o]), 32'd1);
        if (ref_en) begin
          exp_idx = ref_next_grant(req_i, last_served);
          check_value("idx_o", 32'(idx_o), exp_idx);
        end
        last_served = int'(idx_o);
      end else begin
        check_value("gnt_o", 32'(gnt_o), 32'd0);
      end
      // a flush sends the pointer back to input 0
      if (flush_i) begin
        last_served = -1;
      end
    end
  end

  initial begin : p_watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin : p_main
    int          err_start, got;
    logic        xfer;
    idx_t        xfer_idx, first_idx;
    data_t       first_data;
    logic [31:0] r;
    seed         = 32'h2729;
    errors       = 0;
    check_count  = 0;
    fault_cycles = 0;
    last_served  = -1;
    check_en     = 1'b0;
    ref_en       = 1'b1;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    gnt_i        = 1'b0;
    req_i        = '0;
    xfer         = 1'b0;
    xfer_idx     = '0;
    fill_random_data();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_ni   = 1'b1;
    check_en = 1'b1;

    // test 1: fixed requests, the checker follows the reference order
    err_start = errors;
    req_i = ROT_REQ;
    gnt_i = 1'b1;
    for (int n = 0; n < ROT_XFERS; n++) begin
      wait_transfer(got);
    end
    report_test(1, "fair rotation", err_start);

    // test 2: random traffic, a request only leaves once it was served
    err_start = errors;
    ref_en = 1'b0;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      @(posedge clk_i);
      #1;
      r = next_random();
      if (xfer) begin
        req_i[xfer_idx] = 1'b0;
      end
      req_i = req_i | (r[7:0] & r[15:8] & r[23:16]);
      gnt_i = r[24] | r[25];
      fill_random_data();
      @(negedge clk_i);
      xfer     = req_o && gnt_i;
      xfer_idx = idx_o;
    end
    @(posedge clk_i);
    #1;
    report_test(2, "datapath consistency", err_start);

    // test 3: back-pressure with lower inputs joining late
    err_start = errors;
    drain();
    req_i = LOCK_REQ;
    gnt_i = 1'b0;
    fill_random_data();
    @(negedge clk_i);
    first_idx  = idx_o;
    first_data = data_o;
    check_value("idx_o first decision", 32'(first_idx), ref_next_grant(LOCK_REQ, -1));
    for (int k = 0; k < LOCK_HOLD; k++) begin
      @(posedge clk_i);
      #1;
      // each of these would win if the decision were not locked
      req_i[k] = 1'b1;
      @(negedge clk_i);
      check_value("idx_o while locked", 32'(idx_o), 32'(first_idx));
      check_value("data_o while locked", data_o, first_data);
    end
    @(posedge clk_i);
    #1;
    gnt_i = 1'b1;
    wait_transfer(got);
    check_value("idx_o at release", got, 32'(first_idx));
    report_test(3, "lock-in", err_start);

    // test 4: transfers move the pointer, a flush brings it back
    err_start = errors;
    @(posedge clk_i);
    #1;
    drain();
    ref_en = 1'b1;
    req_i  = FLUSH_REQ;
    gnt_i  = 1'b1;
    fill_random_data();
    for (int n = 0; n < FLUSH_XFERS; n++) begin
      wait_transfer(got);
    end
    @(posedge clk_i);
    #1;
    gnt_i   = 1'b0;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    gnt_i   = 1'b1;
    wait_transfer(got);
    check_value("idx_o after flush", got, ref_next_grant(FLUSH_REQ, -1));
    report_test(4, "flush", err_start);

    $display("test 5 no fault: %0d cycles with fault_o high", fault_cycles);
    $display("summary: 5 tests, %0d checks, %0d errors", check_count, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== tmr_rr_arb.sv ====
// top of the triple-redundant round-robin arbiter
// three state blocks and trees, peer routing, output voters and data mux
`timescale 1ns/1ps
`include "arb_settings.svh"

module tmr_rr_arb import arb_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  req_vec_t                   req_i,
  input  data_t    [`ARB_NUM_IN-1:0] data_i,
  input  logic                       gnt_i,
  output logic                       req_o,
  output req_vec_t                   gnt_o,
  output idx_t                       idx_o,
  output data_t                      data_o,
  output logic                       fault_o
);

  // per-replica next values shared with the peers
  idx_t      [2:0] rr_next;
  logic      [2:0] lock_next;
  req_vec_t  [2:0] req_next;

  // per-replica links between state block and tree
  idx_t      [2:0] rr_q;
  req_vec_t  [2:0] req_eff;
  logic      [2:0] req_out;
  idx_t      [2:0] idx_out;
  req_vec_t  [2:0] gnt_out;
  node_sel_t [2:0] node_sel;

  logic      [2:0] state_fault;
  logic            gnt_fault, req_fault, idx_fault, mux_fault;

  ////////////////////////////////////////
  // replicas
  ////////////////////////////////////////
  for (genvar i = 0; i < 3; i++) begin : gen_replica
    idx_t     [1:0] peer_rr;
    logic     [1:0] peer_lock;
    req_vec_t [1:0] peer_req;

    // each replica sees the other two in rotating order
    for (genvar j = 0; j < 2; j++) begin : gen_peer
      assign peer_rr[j]   = rr_next[(i + j + 1) % 3];
      assign peer_lock[j] = lock_next[(i + j + 1) % 3];
      assign peer_req[j]  = req_next[(i + j + 1) % 3];
    end

    rr_state i_state (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .flush_i     (flush_i),
      .req_i       (req_i),
      .req_out_i   (req_out[i]),
      .gnt_i       (gnt_i),
      .peer_rr_i   (peer_rr),
      .peer_lock_i (peer_lock),
      .peer_req_i  (peer_req),
      .rr_next_o   (rr_next[i]),
      .lock_next_o (lock_next[i]),
      .req_next_o  (req_next[i]),
      .rr_o        (rr_q[i]),
      .req_eff_o   (req_eff[i]),
      .fault_o     (state_fault[i])
    );

    arb_tree i_tree (
      .req_eff_i  (req_eff[i]),
      .rr_i       (rr_q[i]),
      .gnt_i      (gnt_i),
      .req_o      (req_out[i]),
      .idx_o      (idx_out[i]),
      .gnt_o      (gnt_out[i]),
      .node_sel_o (node_sel[i])
    );
  end

  ////////////////////////////////////////
  // output voting
  ////////////////////////////////////////
  tmr_voter #(.WIDTH(`ARB_NUM_IN)) i_gnt_vote (
    .a_i (gnt_out[0]), .b_i (gnt_out[1]), .c_i (gnt_out[2]),
    .majority_o (gnt_o), .fault_o (gnt_fault)
  );

  tmr_voter #(.WIDTH(1)) i_req_vote (
    .a_i (req_out[0]), .b_i (req_out[1]), .c_i (req_out[2]),
    .majority_o (req_o), .fault_o (req_fault)
  );

  tmr_voter #(.WIDTH(`ARB_IDX_W)) i_idx_vote (
    .a_i (idx_out[0]), .b_i (idx_out[1]), .c_i (idx_out[2]),
    .majority_o (idx_o), .fault_o (idx_fault)
  );

  // the payload is steered by the voted selects rather than voted itself
  data_mux_tree i_data_mux (
    .node_sel_i (node_sel),
    .data_i     (data_i),
    .data_o     (data_o),
    .fault_o    (mux_fault)
  );

  assign fault_o = |state_fault | gnt_fault | req_fault | idx_fault | mux_fault;

endmodule

// ==== tmr_voter.sv ====
// bitwise two-out-of-three majority voter
// flags any disagreement between the three copies
`timescale 1ns/1ps

module tmr_voter #(
  parameter int unsigned WIDTH = 1
) (
  input  logic [WIDTH-1:0] a_i,
  input  logic [WIDTH-1:0] b_i,
  input  logic [WIDTH-1:0] c_i,
  output logic [WIDTH-1:0] majority_o,
  output logic             fault_o
);

  // a bit is set when at least two of the copies have it set
  assign majority_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  // any copy that differs from another one is a fault
  // a single upset shows up here even though the vote masks it
  assign fault_o = |((a_i ^ b_i) | (a_i ^ c_i));

endmodule
